//--- dot_lane.sv
// *********************************************************************
// Chunked signed multiply-accumulate lane for one matrix row
// *********************************************************************

`timescale 1ns/1ps

module dot_lane #(
    parameter int DATA_W = matmul_pkg::DEF_DATA_W,
    parameter int CHUNK  = matmul_pkg::DEF_CHUNK,
    parameter int INNER  = matmul_pkg::DEF_INNER
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     beat_valid,
    input  logic                     beat_first,
    input  logic                     beat_last,
    input  logic [DATA_W*CHUNK-1:0]  a_word,
    input  logic [DATA_W*CHUNK-1:0]  w_word,
    output logic                     sum_valid,
    output logic signed [ACC_W-1:0]  sum
);

    // Sum width covers INNER worst case products
    localparam int ACC_W = 2*DATA_W + $clog2(INNER);

    logic signed [2*DATA_W-1:0] prod [CHUNK];  // Per element products
    logic signed [ACC_W-1:0]    beat_sum;      // All products of one word
    logic signed [ACC_W-1:0]    acc;           // Running total
    logic signed [ACC_W-1:0]    acc_next;

    // Element i sits at bits i*DATA_W upward, lane 0 lowest
    for (genvar i = 0; i < CHUNK; i++) begin : g_mul
        assign prod[i] = $signed(a_word[i*DATA_W +: DATA_W])
                       * $signed(w_word[i*DATA_W +: DATA_W]);
    end

    // Adder tree over one word, sign extended to ACC_W
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < CHUNK; i++) begin
            beat_sum = beat_sum + ACC_W'(prod[i]);
        end
    end

    // First beat restarts the total
    assign acc_next = beat_first ? beat_sum : acc + beat_sum;

    // Accumulator, no reset since beat_first reloads it
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            acc <= acc_next;
        end
        if (beat_valid && beat_last) begin
            sum <= acc_next;  // Final total incl. last product
        end
    end

    // One cycle valid pulse after the last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= beat_valid && beat_last;
        end
    end

endmodule

//--- filelist.f
+incdir+.
matmul_pkg.sv
matrix_bank.sv
dot_lane.sv
matmul_ctrl.sv
result_port.sv
matmul_top.sv
tb_matmul.sv

//--- matmul_ctrl.sv
// *********************************************************************
// Run sequencer: row pairs, columns, bank read addresses and done
// *********************************************************************

`timescale 1ns/1ps

module matmul_ctrl #(
    parameter int ROWS  = matmul_pkg::DEF_ROWS,
    parameter int COLS  = matmul_pkg::DEF_COLS,
    parameter int INNER = matmul_pkg::DEF_INNER,
    parameter int CHUNK = matmul_pkg::DEF_CHUNK
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             port_free,
    output logic             rd_en,
    output logic [AB_AW-1:0] a_rd_addr,
    output logic [W_AW-1:0]  w_rd_addr,
    output logic             beat_valid,
    output logic             beat_first,
    output logic             beat_last,
    output logic [PW-1:0]    pair_idx,
    output logic [CW-1:0]    col_idx,
    output logic             busy,
    output logic             done
);

    localparam int WPR   = INNER / CHUNK;                        // Words per row
    localparam int PAIRS = ROWS / 2;
    localparam int AB_AW = (PAIRS*WPR > 1) ? $clog2(PAIRS*WPR) : 1;
    localparam int W_AW  = (COLS*WPR > 1) ? $clog2(COLS*WPR) : 1;
    localparam int PW    = (PAIRS > 1) ? $clog2(PAIRS) : 1;
    localparam int CW    = (COLS > 1) ? $clog2(COLS) : 1;
    localparam int WCW   = (WPR > 1) ? $clog2(WPR) : 1;

    matmul_pkg::ctrl_state_t state;

    logic [WCW-1:0] word_cnt;
    logic [PW-1:0]  pair_cnt;
    logic [CW-1:0]  col_cnt;
    logic           drain_cnt;  // Two drain cycles
    logic           word_last;
    logic           col_last;
    logic           pair_last;
    logic           first;

    assign word_last = (word_cnt == WCW'(WPR - 1));
    assign col_last  = (col_cnt == CW'(COLS - 1));
    assign pair_last = (pair_cnt == PW'(PAIRS - 1));

    // Read side, live only while issuing
    assign rd_en     = (state == matmul_pkg::ST_ISSUE);
    assign first     = rd_en && (word_cnt == '0);
    assign a_rd_addr = AB_AW'(pair_cnt * WPR + word_cnt);  // Same row in both A banks
    assign w_rd_addr = W_AW'(col_cnt * WPR + word_cnt);

    // Indices stay put until HOLD, result port samples them
    assign pair_idx = pair_cnt;
    assign col_idx  = col_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= matmul_pkg::ST_IDLE;
            word_cnt  <= '0;
            pair_cnt  <= '0;
            col_cnt   <= '0;
            drain_cnt <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                matmul_pkg::ST_IDLE, matmul_pkg::ST_DONE: begin
                    if (start) begin
                        word_cnt <= '0;
                        pair_cnt <= '0;
                        col_cnt  <= '0;
                        busy     <= 1'b1;
                        done     <= 1'b0;
                        state    <= matmul_pkg::ST_ISSUE;
                    end
                end
                matmul_pkg::ST_ISSUE: begin
                    if (word_last) begin
                        word_cnt  <= '0;
                        drain_cnt <= 1'b0;
                        state     <= matmul_pkg::ST_DRAIN;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                // Bank cycle then lane sum, port captures after that
                matmul_pkg::ST_DRAIN: begin
                    if (drain_cnt) begin
                        state <= matmul_pkg::ST_HOLD;
                    end
                    drain_cnt <= 1'b1;
                end
                matmul_pkg::ST_HOLD: begin
                    if (port_free) begin
                        if (col_last && pair_last) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= matmul_pkg::ST_DONE;
                        end else begin
                            if (col_last) begin  // Next row pair
                                col_cnt  <= '0;
                                pair_cnt <= pair_cnt + 1'b1;
                            end else begin
                                col_cnt <= col_cnt + 1'b1;
                            end
                            state <= matmul_pkg::ST_ISSUE;
                        end
                    end
                end
                default: state <= matmul_pkg::ST_IDLE;
            endcase
        end
    end

    // Beat flags follow the bank latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
            beat_first <= 1'b0;
            beat_last  <= 1'b0;
        end else begin
            beat_valid <= rd_en;
            beat_first <= first;
            beat_last  <= rd_en && word_last;
        end
    end

endmodule

//--- matmul_pkg.sv
// *********************************************************************
// Controller state encoding and default matrix sizes
// *********************************************************************

package matmul_pkg;

    // Run sequencer states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,  // Waiting for start
        ST_ISSUE = 3'd1,  // Reading one row pair against one weight row
        ST_DRAIN = 3'd2,  // Bank and lane pipeline emptying
        ST_HOLD  = 3'd3,  // Result port still busy
        ST_DONE  = 3'd4   // All entries delivered
    } ctrl_state_t;

    localparam int DEF_DATA_W = 8;   // Element width
    localparam int DEF_CHUNK  = 2;   // Elements per memory word
    localparam int DEF_INNER  = 8;   // Inner dimension, multiple of chunk
    localparam int DEF_ROWS   = 4;   // Rows of A, even
    localparam int DEF_COLS   = 4;   // Columns of C, rows of W

endpackage

//--- matmul_top.sv
// *********************************************************************
// Matrix multiply engine top: banks, sequencer, lanes, result port
// *********************************************************************

`timescale 1ns/1ps

module matmul_top #(
    parameter int DATA_W = matmul_pkg::DEF_DATA_W,
    parameter int CHUNK  = matmul_pkg::DEF_CHUNK,
    parameter int INNER  = matmul_pkg::DEF_INNER,
    parameter int ROWS   = matmul_pkg::DEF_ROWS,
    parameter int COLS   = matmul_pkg::DEF_COLS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    a_wr_en,
    input  logic [A_AW-1:0]         a_wr_addr,
    input  logic [WORD_W-1:0]       a_wr_data,
    input  logic                    w_wr_en,
    input  logic [W_AW-1:0]         w_wr_addr,
    input  logic [WORD_W-1:0]       w_wr_data,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output logic                    res_req,
    input  logic                    res_ack,
    output logic [PW-1:0]           res_row_pair,
    output logic [CW-1:0]           res_col,
    output logic signed [ACC_W-1:0] res_even,
    output logic signed [ACC_W-1:0] res_odd
);

    localparam int WPR    = INNER / CHUNK;
    localparam int WORD_W = DATA_W * CHUNK;
    localparam int ACC_W  = 2*DATA_W + $clog2(INNER);
    localparam int A_AW   = (ROWS*WPR > 1) ? $clog2(ROWS*WPR) : 1;      // External A
    localparam int AB_AW  = (ROWS/2*WPR > 1) ? $clog2(ROWS/2*WPR) : 1;  // Per A bank
    localparam int W_AW   = (COLS*WPR > 1) ? $clog2(COLS*WPR) : 1;
    localparam int PW     = (ROWS/2 > 1) ? $clog2(ROWS/2) : 1;
    localparam int CW     = (COLS > 1) ? $clog2(COLS) : 1;

    logic [A_AW-1:0]   a_row;        // Row of the incoming A word
    logic [A_AW-1:0]   a_word;       // Word inside that row
    logic [AB_AW-1:0]  a_bank_addr;
    logic              a_even_wr;
    logic              a_odd_wr;

    logic              rd_en;
    logic [AB_AW-1:0]  a_rd_addr;
    logic [W_AW-1:0]   w_rd_addr;
    logic [WORD_W-1:0] a_even_word;
    logic [WORD_W-1:0] a_odd_word;
    logic [WORD_W-1:0] w_word;
    logic              beat_valid;
    logic              beat_first;
    logic              beat_last;
    logic [PW-1:0]     pair_idx;
    logic [CW-1:0]     col_idx;
    logic              port_free;
    logic              even_valid;
    logic signed [ACC_W-1:0] even_sum;
    logic signed [ACC_W-1:0] odd_sum;

    // A write steering by row parity
    assign a_row       = a_wr_addr / A_AW'(WPR);
    assign a_word      = a_wr_addr % A_AW'(WPR);
    assign a_bank_addr = AB_AW'((a_row >> 1) * A_AW'(WPR) + a_word);
    assign a_even_wr   = a_wr_en && !a_row[0];
    assign a_odd_wr    = a_wr_en && a_row[0];

    matrix_bank #(.DEPTH(ROWS/2*WPR), .WORD_W(WORD_W)) i_a_even_bank (
        .clk(clk), .wr_en(a_even_wr), .wr_addr(a_bank_addr), .wr_data(a_wr_data),
        .rd_en(rd_en), .rd_addr(a_rd_addr), .rd_data(a_even_word)
    );

    matrix_bank #(.DEPTH(ROWS/2*WPR), .WORD_W(WORD_W)) i_a_odd_bank (
        .clk(clk), .wr_en(a_odd_wr), .wr_addr(a_bank_addr), .wr_data(a_wr_data),
        .rd_en(rd_en), .rd_addr(a_rd_addr), .rd_data(a_odd_word)
    );

    // One weight row per output column
    matrix_bank #(.DEPTH(COLS*WPR), .WORD_W(WORD_W)) i_w_bank (
        .clk(clk), .wr_en(w_wr_en), .wr_addr(w_wr_addr), .wr_data(w_wr_data),
        .rd_en(rd_en), .rd_addr(w_rd_addr), .rd_data(w_word)
    );

    matmul_ctrl #(.ROWS(ROWS), .COLS(COLS), .INNER(INNER), .CHUNK(CHUNK)) i_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .port_free(port_free),
        .rd_en(rd_en), .a_rd_addr(a_rd_addr), .w_rd_addr(w_rd_addr),
        .beat_valid(beat_valid), .beat_first(beat_first), .beat_last(beat_last),
        .pair_idx(pair_idx), .col_idx(col_idx), .busy(busy), .done(done)
    );

    // Both lanes share the weight word
    dot_lane #(.DATA_W(DATA_W), .CHUNK(CHUNK), .INNER(INNER)) i_lane_even (
        .clk(clk), .rst_n(rst_n),
        .beat_valid(beat_valid), .beat_first(beat_first), .beat_last(beat_last),
        .a_word(a_even_word), .w_word(w_word), .sum_valid(even_valid), .sum(even_sum)
    );

    dot_lane #(.DATA_W(DATA_W), .CHUNK(CHUNK), .INNER(INNER)) i_lane_odd (
        .clk(clk), .rst_n(rst_n),
        .beat_valid(beat_valid), .beat_first(beat_first), .beat_last(beat_last),
        .a_word(a_odd_word), .w_word(w_word), .sum_valid(), .sum(odd_sum)  // Lockstep
    );

    result_port #(.DATA_W(DATA_W), .INNER(INNER), .ROWS(ROWS), .COLS(COLS)) i_result_port (
        .clk(clk), .rst_n(rst_n), .even_valid(even_valid),
        .even_sum(even_sum), .odd_sum(odd_sum), .pair_idx(pair_idx), .col_idx(col_idx),
        .port_free(port_free), .res_req(res_req), .res_ack(res_ack),
        .res_row_pair(res_row_pair), .res_col(res_col),
        .res_even(res_even), .res_odd(res_odd)
    );

endmodule

//--- matrix_bank.sv
// *********************************************************************
// Single write, single read storage bank with registered read
// *********************************************************************

`timescale 1ns/1ps

module matrix_bank #(
    parameter int DEPTH  = 16,
    parameter int WORD_W = 16
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [AW-1:0]     wr_addr,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_en,
    input  logic [AW-1:0]     rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    // Address width, at least one bit even for a single word
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WORD_W-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, one cycle latency
    // Output holds its last word while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- result_port.sv
// *********************************************************************
// Result record holder with four-phase req/ack sender
// *********************************************************************

`timescale 1ns/1ps

module result_port #(
    parameter int DATA_W = matmul_pkg::DEF_DATA_W,
    parameter int INNER  = matmul_pkg::DEF_INNER,
    parameter int ROWS   = matmul_pkg::DEF_ROWS,
    parameter int COLS   = matmul_pkg::DEF_COLS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    even_valid,
    input  logic signed [ACC_W-1:0] even_sum,
    input  logic signed [ACC_W-1:0] odd_sum,
    input  logic [PW-1:0]           pair_idx,
    input  logic [CW-1:0]           col_idx,
    output logic                    port_free,
    output logic                    res_req,
    input  logic                    res_ack,
    output logic [PW-1:0]           res_row_pair,
    output logic [CW-1:0]           res_col,
    output logic signed [ACC_W-1:0] res_even,
    output logic signed [ACC_W-1:0] res_odd
);

    localparam int ACC_W = 2*DATA_W + $clog2(INNER);
    localparam int PW    = (ROWS/2 > 1) ? $clog2(ROWS/2) : 1;
    localparam int CW    = (COLS > 1) ? $clog2(COLS) : 1;

    logic holding;  // Record captured, handshake not finished

    // Free once empty, or req and ack are both back low
    assign port_free = !holding || (!res_req && !res_ack);

    // Four-phase sender
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            holding <= 1'b0;
            res_req <= 1'b0;
        end else if (even_valid) begin
            holding <= 1'b1;
            res_req <= 1'b1;
        end else if (res_req && res_ack) begin
            res_req <= 1'b0;  // Ack seen, drop req
        end else if (holding && !res_req && !res_ack) begin
            holding <= 1'b0;  // Handshake complete once req and ack are low
        end
    end

    // Lanes are lockstep so even_valid covers both sums
    // Held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (even_valid) begin
            res_even     <= even_sum;
            res_odd      <= odd_sum;
            res_row_pair <= pair_idx;
            res_col      <= col_idx;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the matrix multiply testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_matmul -f filelist.f -o tb_matmul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_matmul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished without errors"
exit 0

//--- tb_matmul_check.svh
// *********************************************************************
// Model arrays, word packing, reference product and compare tasks
// *********************************************************************

`ifndef TB_MATMUL_CHECK_SVH
`define TB_MATMUL_CHECK_SVH

logic signed [DATA_W-1:0] a_mat [ROWS][INNER];  // Input matrix
logic signed [DATA_W-1:0] w_mat [COLS][INNER];  // One weight row per column
logic signed [ACC_W-1:0]  exp_c [ROWS][COLS];   // Expected products

// Element k of a row goes to lane k mod CHUNK of word k/CHUNK
function automatic logic [WORD_W-1:0] pack_a(input int r, input int w);
    logic [WORD_W-1:0] packed_word;
    for (int i = 0; i < CHUNK; i++) begin
        packed_word[i*DATA_W +: DATA_W] = a_mat[r][w*CHUNK + i];
    end
    return packed_word;
endfunction

function automatic logic [WORD_W-1:0] pack_w(input int c, input int w);
    logic [WORD_W-1:0] packed_word;
    for (int i = 0; i < CHUNK; i++) begin
        packed_word[i*DATA_W +: DATA_W] = w_mat[c][w*CHUNK + i];
    end
    return packed_word;
endfunction

// Plain dot products over the inner dimension
function automatic void compute_model();
    int acc;
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            acc = 0;
            for (int k = 0; k < INNER; k++) begin
                acc += int'(a_mat[r][k]) * int'(w_mat[c][k]);
            end
            exp_c[r][c] = ACC_W'(acc);
        end
    end
endfunction

task automatic check_sum(input string name, input logic signed [ACC_W-1:0] exp_v,
                         input logic signed [ACC_W-1:0] act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp_v, act_v));
    end
endtask

task automatic check_index(input string name, input logic [IDX_W-1:0] exp_v,
                           input logic [IDX_W-1:0] act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp_v, act_v));
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp_v, act_v));
    end
endtask

`endif

//--- tb_matmul.sv
// *********************************************************************
// Matrix multiply testbench: clock, reset, loading, runs, req/ack responder
// *********************************************************************

`timescale 1ns/1ps

module tb_matmul;

    localparam int DATA_W  = matmul_pkg::DEF_DATA_W;
    localparam int CHUNK   = matmul_pkg::DEF_CHUNK;
    localparam int INNER   = matmul_pkg::DEF_INNER;
    localparam int ROWS    = matmul_pkg::DEF_ROWS;
    localparam int COLS    = matmul_pkg::DEF_COLS;
    localparam int WPR     = INNER / CHUNK;
    localparam int WORD_W  = DATA_W * CHUNK;
    localparam int ACC_W   = 2*DATA_W + $clog2(INNER);
    localparam int A_AW    = (ROWS*WPR > 1) ? $clog2(ROWS*WPR) : 1;
    localparam int W_AW    = (COLS*WPR > 1) ? $clog2(COLS*WPR) : 1;
    localparam int PW      = (ROWS/2 > 1) ? $clog2(ROWS/2) : 1;
    localparam int CW      = (COLS > 1) ? $clog2(COLS) : 1;
    localparam int IDX_W   = (PW > CW) ? PW : CW;  // Common index compare width
    localparam int TIMEOUT = 200;                  // Cycles per wait

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    a_wr_en;
    logic [A_AW-1:0]         a_wr_addr;
    logic [WORD_W-1:0]       a_wr_data;
    logic                    w_wr_en;
    logic [W_AW-1:0]         w_wr_addr;
    logic [WORD_W-1:0]       w_wr_data;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    res_req;
    logic                    res_ack;
    logic [PW-1:0]           res_row_pair;
    logic [CW-1:0]           res_col;
    logic signed [ACC_W-1:0] res_even;
    logic signed [ACC_W-1:0] res_odd;

    int seed = 32'hdf80_86eb;  // Fixed stimulus seed

    matmul_top #(
        .DATA_W(DATA_W), .CHUNK(CHUNK), .INNER(INNER), .ROWS(ROWS), .COLS(COLS)
    ) i_matmul_top (
        .clk(clk), .rst_n(rst_n),
        .a_wr_en(a_wr_en), .a_wr_addr(a_wr_addr), .a_wr_data(a_wr_data),
        .w_wr_en(w_wr_en), .w_wr_addr(w_wr_addr), .w_wr_data(w_wr_data),
        .start(start), .busy(busy), .done(done),
        .res_req(res_req), .res_ack(res_ack),
        .res_row_pair(res_row_pair), .res_col(res_col),
        .res_even(res_even), .res_odd(res_odd)
    );

    always #10 clk = ~clk;  // 20 ns period

    // Controller state shows where a stalled run stopped
    task automatic abort_run(input string what);
        matmul_pkg::ctrl_state_t st;
        st = i_matmul_top.i_ctrl.state;
        $display("%s (controller in %s)", what, st.name());
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_matmul_check.svh"

    task automatic wait_req(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (res_req !== level) begin
            if (cnt == TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for %s", what));
            end
            @(posedge clk);
            cnt++;
        end
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        while (done !== 1'b1) begin
            if (cnt == TIMEOUT) begin
                abort_run("Timed out waiting for done after the last result");
            end
            @(posedge clk);
            cnt++;
        end
    endtask

    task automatic fill_random_a();
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < INNER; k++) begin
                a_mat[r][k] = DATA_W'($random(seed));
            end
        end
    endtask

    task automatic fill_random_w();
        for (int c = 0; c < COLS; c++) begin
            for (int k = 0; k < INNER; k++) begin
                w_mat[c][k] = DATA_W'($random(seed));
            end
        end
    endtask

    // Every element at the most negative value
    task automatic fill_most_negative();
        for (int k = 0; k < INNER; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                a_mat[r][k] = {1'b1, {(DATA_W-1){1'b0}}};
            end
            for (int c = 0; c < COLS; c++) begin
                w_mat[c][k] = {1'b1, {(DATA_W-1){1'b0}}};
            end
        end
    endtask

    task automatic load_a();
        for (int r = 0; r < ROWS; r++) begin
            for (int w = 0; w < WPR; w++) begin
                @(posedge clk);
                a_wr_en   <= 1'b1;
                a_wr_addr <= A_AW'(r*WPR + w);  // Row major external address
                a_wr_data <= pack_a(r, w);
            end
        end
        @(posedge clk);
        a_wr_en <= 1'b0;
    endtask

    task automatic load_w();
        for (int c = 0; c < COLS; c++) begin
            for (int w = 0; w < WPR; w++) begin
                @(posedge clk);
                w_wr_en   <= 1'b1;
                w_wr_addr <= W_AW'(c*WPR + w);
                w_wr_data <= pack_w(c, w);
            end
        end
        @(posedge clk);
        w_wr_en <= 1'b0;
    endtask

    task automatic check_entry(input int p, input int c);
        check_index("res_row_pair", IDX_W'(p), IDX_W'(res_row_pair));
        check_index("res_col", IDX_W'(c), IDX_W'(res_col));
        check_sum("res_even", exp_c[2*p][c], res_even);
        check_sum("res_odd", exp_c[2*p+1][c], res_odd);
    endtask

    // One full run as the req/ack responder with random delays
    task automatic run_matmul(input bit poke_start);
        int delay;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_flag("busy", 1'b1, busy);
        check_flag("done", 1'b0, done);
        for (int p = 0; p < ROWS/2; p++) begin
            for (int c = 0; c < COLS; c++) begin
                wait_req(1'b1, $sformatf("res_req of pair %0d column %0d", p, c));
                check_entry(p, c);
                check_flag("busy", 1'b1, busy);  // Run still going
                check_flag("done", 1'b0, done);
                if (poke_start && p == 0 && c == 0) begin
                    start <= 1'b1;  // Ignored while busy
                    @(posedge clk);
                    start <= 1'b0;
                end
                delay = int'($unsigned($random(seed)) % 8);
                repeat (delay) begin
                    @(posedge clk);
                    check_flag("res_req", 1'b1, res_req);  // No drop before ack
                    check_entry(p, c);
                end
                res_ack <= 1'b1;
                wait_req(1'b0, $sformatf("res_req to drop after ack, pair %0d", p));
                delay = int'($unsigned($random(seed)) % 4);
                repeat (delay) begin
                    @(posedge clk);
                    check_flag("res_req", 1'b0, res_req);  // Ack still high
                end
                res_ack <= 1'b0;
            end
        end
        wait_done();
        check_flag("busy", 1'b0, busy);
        check_flag("res_req", 1'b0, res_req);
        repeat (4) begin
            @(posedge clk);
            check_flag("res_req", 1'b0, res_req);  // No extra result
            check_flag("done", 1'b1, done);
        end
    endtask

    initial begin
        rst_n     <= 1'b0;
        a_wr_en   <= 1'b0;
        a_wr_addr <= '0;
        a_wr_data <= '0;
        w_wr_en   <= 1'b0;
        w_wr_addr <= '0;
        w_wr_data <= '0;
        start     <= 1'b0;
        res_ack   <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_flag("res_req", 1'b0, res_req);
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);

        // Random A and W with a stray start during the run
        fill_random_a();
        fill_random_w();
        load_a();
        load_w();
        compute_model();
        run_matmul(1'b1);

        // New weights while A stays in the banks
        fill_random_w();
        load_w();
        compute_model();
        run_matmul(1'b0);

        // Largest magnitude sums
        fill_most_negative();
        load_a();
        load_w();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                exp_c[r][c] = ACC_W'(INNER * (1 << (2*DATA_W - 2)));
            end
        end
        run_matmul(1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule
